// File: Makefile
VERILATOR  ?= verilator
TOP        := io_house_tb
FILELIST   := io_house.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
# checker $error keeps running so the testbench can end the run itself
RUN_FLAGS  := +verilator+error+limit+100
SOURCES    := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: io_house.f
rtl/io_house_pkg.sv
rtl/io_decode.sv
rtl/board_ctrl_regs.sv
rtl/tick_timer.sv
rtl/io_timeout_ack.sv
rtl/io_resp_merge.sv
rtl/io_house_top.sv
test/io_house_checker.sv
test/io_house_tb.sv

// File: rtl/board_ctrl_regs.sv
`timescale 1ns/1ps

module board_ctrl_regs #(
	parameter int RST_PULSE_LOG2 = io_house_pkg::RST_PULSE_LOG2_DFLT
) (
	input  logic                    clk100,
	input  logic                    rst,
	input  io_house_pkg::io_req_t   req_i,
	input  io_house_pkg::io_sel_t   sel_i,
	output io_house_pkg::io_resp_t  resp_o,
	output io_house_pkg::led_t      led_o,
	output io_house_pkg::core_rst_t core_rst_o,
	output io_house_pkg::clk_en_t   clk_en_o
);
	import io_house_pkg::*;

	led_t                  led_q;
	core_rst_t             rst_reg;     // value of the last reset write
	logic [RST_PULSE_LOG2:0] rst_cnt;   // top bit set = pulse done
	clk_en_t               clk_en_q;

	logic wr_leds;
	logic wr_rst_lo;    // byte lanes 0/1, reset lines
	logic wr_rst_hi;    // byte lanes 2/3, clock gates
	logic pulse_done;

	assign wr_leds    = sel_i.leds & req_i.we;
	assign wr_rst_lo  = sel_i.core_rst & req_i.we & (|req_i.sel[1:0]);
	assign wr_rst_hi  = sel_i.core_rst & req_i.we & (|req_i.sel[3:2]);
	assign pulse_done = rst_cnt[RST_PULSE_LOG2];

	// ------------------------------------------------------------------
	// led register
	// ------------------------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst)
			led_q <= '0;
		else if (wr_leds)
			led_q <= req_i.dat[7:0];   // low byte only
	end

	// ------------------------------------------------------------------
	// core reset register and pulse counter
	// ------------------------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			rst_reg <= '0;
			rst_cnt <= {1'b1, {RST_PULSE_LOG2{1'b0}}};   // start out expired
		end else begin
			if (!pulse_done)
				rst_cnt <= rst_cnt + 1'b1;
			else
				rst_reg <= '0;               // pulse over, drop the lines
			// a fresh write wins over the clear
			if (wr_rst_lo) begin
				rst_reg <= req_i.dat[15:0];
				rst_cnt <= '0;               // restart pulse
			end
		end
	end

	// clock gates, upper lanes load all three bits
	always_ff @(posedge clk100) begin
		if (rst)
			clk_en_q <= CLK_EN_INIT;
		else if (wr_rst_hi)
			clk_en_q <= req_i.dat[18:16];
		else if (wr_rst_lo)
			clk_en_q[2] <= clk_en_q[2] | (|req_i.dat[5:4]);   // resetting core 2 wakes it
	end

	// ------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------
	assign led_o      = led_q;
	assign core_rst_o = rst_reg & {$bits(core_rst_t){~pulse_done}};   // held for the pulse only
	assign clk_en_o   = clk_en_q;

	// acks are a level while selected, merge registers them
	always_comb begin
		resp_o     = '0;
		resp_o.ack = sel_i.leds | sel_i.core_rst;
		if (sel_i.leds)
			resp_o.dat = {24'h0, led_q};   // readback
		// reset block reads as zero
	end

endmodule

// File: rtl/io_decode.sv
`timescale 1ns/1ps

module io_decode (
	input  io_house_pkg::io_req_t req_i,
	output io_house_pkg::io_sel_t sel_o
);
	import io_house_pkg::*;

	// ------------------------------------------------------------------
	// address compare
	// ------------------------------------------------------------------
	logic        cyc_stb;     // open strobe
	logic [7:0]  adr_page;    // top byte
	logic [17:0] adr_blk;     // 16 kB block number
	logic        hit_page;
	logic        hit_leds;
	logic        hit_rst;

	assign cyc_stb  = req_i.cyc & req_i.stb;
	assign adr_page = req_i.adr[31:24];
	assign adr_blk  = req_i.adr[31:14];

	assign hit_page = (adr_page == IO_PAGE);
	// blocks sit inside the page, so the page
	// hit is implied by a block hit
	assign hit_leds = (adr_blk == LEDS_BLK);
	assign hit_rst  = (adr_blk == CORE_RST_BLK);

	// ------------------------------------------------------------------
	// selects
	// ------------------------------------------------------------------
	// no io bitmap here, every page access is let through
	always_comb begin
		sel_o          = '0;
		sel_o.io_page  = cyc_stb & hit_page;   // feeds the timeout counter
		sel_o.leds     = cyc_stb & hit_leds;
		sel_o.core_rst = cyc_stb & hit_rst;
	end

endmodule

// File: rtl/io_house_pkg.sv
package io_house_pkg;

	// ------------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------------
	typedef logic [31:0] addr_t;        // byte address
	typedef logic [31:0] data_t;        // bus data word
	typedef logic [3:0]  sel_t;         // one bit per byte lane
	typedef logic [7:0]  led_t;         // board leds
	typedef logic [15:0] core_rst_t;    // one reset line per core
	typedef logic [2:0]  clk_en_t;      // core clock gates

	// master request, held until ack
	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		sel_t  sel;
		addr_t adr;
		data_t dat;
	} io_req_t;

	// device or block answer
	typedef struct packed {
		logic  ack;
		data_t dat;
	} io_resp_t;

	// decoded selects, cyc and stb already folded in
	typedef struct packed {
		logic io_page;    // anything in 0xFD
		logic leds;
		logic core_rst;
	} io_sel_t;

	// ------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------
	localparam logic [7:0]  IO_PAGE      = 8'hFD;
	localparam logic [17:0] LEDS_BLK     = 18'h3F7FF;  // 0xFDFFC000 >> 14
	localparam logic [17:0] CORE_RST_BLK = 18'h3F7FC;  // 0xFDFF0000 >> 14

	localparam clk_en_t CLK_EN_INIT = 3'b110;   // cores 1,2 clocked after reset

	// defaults, top level overrides
	localparam int TICK_PERIOD_DFLT    = 1000000;   // 100 Hz at 100 MHz
	localparam int TICK_ON_DFLT        = 150;
	localparam int TICK_OFF_DFLT       = 200;
	localparam int TIMEOUT_LOG2_DFLT   = 5;
	localparam int RST_PULSE_LOG2_DFLT = 6;

endpackage

// File: rtl/io_house_top.sv
`timescale 1ns/1ps

module io_house_top #(
	parameter int TICK_PERIOD    = io_house_pkg::TICK_PERIOD_DFLT,
	parameter int TICK_ON        = io_house_pkg::TICK_ON_DFLT,
	parameter int TICK_OFF       = io_house_pkg::TICK_OFF_DFLT,
	parameter int TIMEOUT_LOG2   = io_house_pkg::TIMEOUT_LOG2_DFLT,
	parameter int RST_PULSE_LOG2 = io_house_pkg::RST_PULSE_LOG2_DFLT
) (
	input  logic                    clk100,
	input  logic                    rst,
	input  io_house_pkg::io_req_t   req_i,
	output io_house_pkg::io_resp_t  resp_o,
	output io_house_pkg::led_t      led_o,
	output io_house_pkg::core_rst_t core_rst_o,
	output io_house_pkg::clk_en_t   clk_en_o,
	output logic                    tick_irq_o
);
	import io_house_pkg::*;

	io_sel_t  sel;          // decoded selects
	io_resp_t board_resp;   // led + reset block answer
	logic     timeout;      // unanswered io page cycle

	// ------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------
	io_decode io_decode_inst (
		.req_i (req_i),
		.sel_o (sel)
	);

	// ------------------------------------------------------------------
	// devices
	// ------------------------------------------------------------------
	board_ctrl_regs #(
		.RST_PULSE_LOG2 (RST_PULSE_LOG2)
	) board_ctrl_regs_inst (
		.clk100     (clk100),
		.rst        (rst),
		.req_i      (req_i),
		.sel_i      (sel),
		.resp_o     (board_resp),
		.led_o      (led_o),
		.core_rst_o (core_rst_o),
		.clk_en_o   (clk_en_o)
	);

	// periodic tick, not on the bus
	tick_timer #(
		.TICK_PERIOD (TICK_PERIOD),
		.TICK_ON     (TICK_ON),
		.TICK_OFF    (TICK_OFF)
	) tick_timer_inst (
		.clk100     (clk100),
		.rst        (rst),
		.tick_irq_o (tick_irq_o)
	);

	io_timeout_ack #(
		.TIMEOUT_LOG2 (TIMEOUT_LOG2)
	) io_timeout_ack_inst (
		.clk100    (clk100),
		.rst       (rst),
		.req_i     (req_i),
		.io_page_i (sel.io_page),
		.timeout_o (timeout)
	);

	// ------------------------------------------------------------------
	// response
	// ------------------------------------------------------------------
	// only one bus device left, its answer goes straight in
	io_resp_merge io_resp_merge_inst (
		.clk100     (clk100),
		.rst        (rst),
		.dev_resp_i (board_resp),
		.timeout_i  (timeout),
		.resp_o     (resp_o)
	);

endmodule

// File: rtl/io_resp_merge.sv
`timescale 1ns/1ps

module io_resp_merge (
	input  logic                   clk100,
	input  logic                   rst,
	input  io_house_pkg::io_resp_t dev_resp_i,
	input  logic                   timeout_i,
	output io_house_pkg::io_resp_t resp_o
);
	import io_house_pkg::*;

	// ------------------------------------------------------------------
	// response register
	// ------------------------------------------------------------------
	// devices answer combinationally, one flop stage here breaks the
	// path back to the master

	localparam data_t ALL_ONES = '1;    // what an empty io slot reads as

	logic  ack_q;
	data_t dat_q;
	data_t dat_nxt;

	// timeout only fires when no device claimed the address
	assign dat_nxt = timeout_i ? ALL_ONES : dev_resp_i.dat;

	always_ff @(posedge clk100) begin
		if (rst)
			ack_q <= 1'b0;
		else
			ack_q <= dev_resp_i.ack | timeout_i;
	end

	// read data, qualified by ack at the master
	always_ff @(posedge clk100) begin
		dat_q <= dat_nxt;
	end

	always_comb begin
		resp_o     = '0;
		resp_o.ack = ack_q;
		resp_o.dat = dat_q;
	end

endmodule

// File: rtl/io_timeout_ack.sv
`timescale 1ns/1ps

module io_timeout_ack #(
	parameter int TIMEOUT_LOG2 = io_house_pkg::TIMEOUT_LOG2_DFLT
) (
	input  logic                  clk100,
	input  logic                  rst,
	input  io_house_pkg::io_req_t req_i,
	input  logic                  io_page_i,
	output logic                  timeout_o
);

	// ------------------------------------------------------------------
	// scan timeout
	// ------------------------------------------------------------------
	// an empty slot in the io page would otherwise hang the master,
	// so after 2^TIMEOUT_LOG2 clocks the cycle is acked anyway

	logic [TIMEOUT_LOG2:0] cnt;     // top bit = expired
	logic                  open;    // master has a strobe up
	logic                  expired;

	assign open    = req_i.cyc & req_i.stb;
	assign expired = cnt[TIMEOUT_LOG2];

	always_ff @(posedge clk100) begin
		if (rst) begin
			cnt       <= '0;
			timeout_o <= 1'b0;
		end else if (!open) begin
			cnt       <= '0;        // cycle ended, rearm
			timeout_o <= 1'b0;
		end else if (io_page_i) begin
			if (!expired)
				cnt <= cnt + 1'b1;   // stops at top, no wrap
			else
				timeout_o <= 1'b1;   // held until stb drops
		end
	end

endmodule

// File: rtl/tick_timer.sv
`timescale 1ns/1ps

module tick_timer #(
	parameter int TICK_PERIOD = io_house_pkg::TICK_PERIOD_DFLT,
	parameter int TICK_ON     = io_house_pkg::TICK_ON_DFLT,
	parameter int TICK_OFF    = io_house_pkg::TICK_OFF_DFLT
) (
	input  logic clk100,
	input  logic rst,
	output logic tick_irq_o
);

	// ------------------------------------------------------------------
	// compare points, counter runs 1..TICK_PERIOD
	// ------------------------------------------------------------------
	localparam logic [23:0] CNT_WRAP = 24'(TICK_PERIOD);
	localparam logic [23:0] CNT_ON   = 24'(TICK_ON);
	localparam logic [23:0] CNT_OFF  = 24'(TICK_OFF);

	logic [23:0] cnt;

	always_ff @(posedge clk100) begin
		if (rst)
			cnt <= 24'd1;
		else if (cnt == CNT_WRAP)
			cnt <= 24'd1;          // one period = TICK_PERIOD clocks
		else
			cnt <= cnt + 24'd1;
	end

	// irq window, high for TICK_OFF - TICK_ON clocks
	always_ff @(posedge clk100) begin
		if (rst)
			tick_irq_o <= 1'b0;
		else if (cnt == CNT_ON)
			tick_irq_o <= 1'b1;
		else if (cnt == CNT_OFF)
			tick_irq_o <= 1'b0;
	end

endmodule

// File: test/io_house_checker.sv
`timescale 1ns/1ps

module io_house_checker #(
	parameter int TICK_PERIOD    = io_house_pkg::TICK_PERIOD_DFLT,
	parameter int TICK_ON        = io_house_pkg::TICK_ON_DFLT,
	parameter int TICK_OFF       = io_house_pkg::TICK_OFF_DFLT,
	parameter int TIMEOUT_LOG2   = io_house_pkg::TIMEOUT_LOG2_DFLT,
	parameter int RST_PULSE_LOG2 = io_house_pkg::RST_PULSE_LOG2_DFLT
) (
	input logic                    clk100,
	input logic                    rst,
	input io_house_pkg::io_req_t   req_i,
	input io_house_pkg::io_resp_t  resp_i,
	input io_house_pkg::led_t      led_i,
	input io_house_pkg::core_rst_t core_rst_i,
	input logic                    tick_irq_i
);
	import io_house_pkg::*;

	logic assert_failed = 1'b0;   // sticky, polled from the testbench

	logic      open;
	logic      mapped;       // led or reset block
	logic      empty_slot;   // io page, nobody home
	logic      led_wr;
	logic      rst_wr;       // low lanes of the reset block
	core_rst_t rst_exp;
	int        pulse_left;   // cycles of reset pulse still due
	int        hi_len;
	int        gap;          // cycles since last tick rise
	logic      tick_q;
	logic      seen_rise;
	int        wait_cnt;

	assign open       = req_i.cyc & req_i.stb;
	assign mapped     = open & (req_i.adr[31:14] == LEDS_BLK || req_i.adr[31:14] == CORE_RST_BLK);
	assign empty_slot = open & (req_i.adr[31:24] == IO_PAGE) & ~mapped;
	assign led_wr     = mapped & req_i.we & (req_i.adr[31:14] == LEDS_BLK);
	assign rst_wr     = mapped & req_i.we & (req_i.adr[31:14] == CORE_RST_BLK) & (|req_i.sel[1:0]);

	// ------------------------------------------------------------------
	// reference models
	// ------------------------------------------------------------------
	always_ff @(posedge clk100) begin
		if (rst) begin
			rst_exp    <= '0;
			pulse_left <= 0;
		end else if (rst_wr) begin
			rst_exp    <= req_i.dat[15:0];
			pulse_left <= 1 << RST_PULSE_LOG2;   // full pulse from the write
		end else if (pulse_left != 0)
			pulse_left <= pulse_left - 1;
	end

	always_ff @(posedge clk100) begin
		if (rst) begin
			tick_q    <= 1'b0;
			hi_len    <= 0;
			gap       <= 0;
			seen_rise <= 1'b0;
		end else begin
			tick_q <= tick_irq_i;
			hi_len <= tick_irq_i ? hi_len + 1 : 0;   // length of current high run
			if (tick_irq_i && !tick_q) begin
				gap       <= 1;
				seen_rise <= 1'b1;
			end else
				gap <= gap + 1;
		end
	end

	always_ff @(posedge clk100) begin
		if (rst || !empty_slot)
			wait_cnt <= 0;
		else
			wait_cnt <= wait_cnt + 1;   // open cycles on an empty slot
	end

	// ------------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------------
	a_ack_early: assert property (@(posedge clk100) disable iff (rst)
		$rose(mapped) |-> !resp_i.ack) else begin
		assert_failed = 1'b1;
		$error("ack high before the request was sampled");
	end

	a_ack_next: assert property (@(posedge clk100) disable iff (rst)
		$rose(mapped) |=> resp_i.ack) else begin
		assert_failed = 1'b1;
		$error("no ack one cycle after a register request");
	end

	a_ack_pulse: assert property (@(posedge clk100) disable iff (rst)
		resp_i.ack && $past(mapped) |=> !resp_i.ack) else begin
		assert_failed = 1'b1;
		$error("register ack longer than one cycle");
	end

	a_led_load: assert property (@(posedge clk100) disable iff (rst)
		led_wr |=> led_i == $past(req_i.dat[7:0])) else begin
		assert_failed = 1'b1;
		$error("led_o did not take the written byte");
	end

	a_rst_pulse: assert property (@(posedge clk100) disable iff (rst)
		core_rst_i == ((pulse_left != 0) ? rst_exp : '0)) else begin
		assert_failed = 1'b1;
		$error("core_rst_o differs from the expected pulse");
	end

	a_tick_len: assert property (@(posedge clk100) disable iff (rst)
		$fell(tick_irq_i) |-> hi_len == TICK_OFF - TICK_ON) else begin
		assert_failed = 1'b1;
		$error("tick interrupt high for the wrong number of cycles");
	end

	a_tick_period: assert property (@(posedge clk100) disable iff (rst)
		$rose(tick_irq_i) && seen_rise |-> gap == TICK_PERIOD) else begin
		assert_failed = 1'b1;
		$error("tick interrupt period is wrong");
	end

	a_to_latency: assert property (@(posedge clk100) disable iff (rst)
		empty_slot |-> wait_cnt <= (1 << TIMEOUT_LOG2) + 2) else begin
		assert_failed = 1'b1;
		$error("empty io slot not acked in time");
	end

	a_to_data: assert property (@(posedge clk100) disable iff (rst)
		resp_i.ack && $past(empty_slot) |-> resp_i.dat == '1) else begin
		assert_failed = 1'b1;
		$error("empty io slot did not read as all ones");
	end

endmodule

// attach to every io_house_top
bind io_house_top io_house_checker #(
	.TICK_PERIOD    (TICK_PERIOD),
	.TICK_ON        (TICK_ON),
	.TICK_OFF       (TICK_OFF),
	.TIMEOUT_LOG2   (TIMEOUT_LOG2),
	.RST_PULSE_LOG2 (RST_PULSE_LOG2)
) io_house_checker_inst (
	.clk100     (clk100),
	.rst        (rst),
	.req_i      (req_i),
	.resp_i     (resp_o),
	.led_i      (led_o),
	.core_rst_i (core_rst_o),
	.tick_irq_i (tick_irq_o)
);

// File: test/io_house_tb.sv
`timescale 1ns/1ps

module io_house_tb;
	import io_house_pkg::*;

	localparam int TICK_PERIOD    = 1000;
	localparam int TICK_ON        = 150;
	localparam int TICK_OFF       = 200;
	localparam int TIMEOUT_LOG2   = 5;
	localparam int RST_PULSE_LOG2 = 6;
	localparam int ACK_LIMIT      = 100;                  // cycles per access
	localparam int PULSE_LIMIT    = (1 << RST_PULSE_LOG2) + 8;
	localparam int TICK_LIMIT     = 3 * TICK_PERIOD;

	localparam addr_t LEDS_ADR  = 32'hFDFF_C000;
	localparam addr_t RST_ADR   = 32'hFDFF_0000;
	localparam addr_t EMPTY_ADR = 32'hFD00_1234;   // io page, no device

	logic        clk100;
	logic        rst;
	io_req_t     req;
	io_resp_t    resp;
	led_t        led;
	core_rst_t   core_rst;
	clk_en_t     clk_en;
	logic        tick_irq;
	logic [15:0] lfsr = 16'd15;

	io_house_top #(
		.TICK_PERIOD    (TICK_PERIOD),
		.TICK_ON        (TICK_ON),
		.TICK_OFF       (TICK_OFF),
		.TIMEOUT_LOG2   (TIMEOUT_LOG2),
		.RST_PULSE_LOG2 (RST_PULSE_LOG2)
	) io_house_top_inst (
		.clk100     (clk100),
		.rst        (rst),
		.req_i      (req),
		.resp_o     (resp),
		.led_o      (led),
		.core_rst_o (core_rst),
		.clk_en_o   (clk_en),
		.tick_irq_o (tick_irq)
	);

	initial begin
		clk100 = 1'b0;
		forever #2 clk100 = ~clk100;   // 250 MHz sim clock
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output data_t val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};   // one step per bit
		end
	endtask

	task automatic abort_run(input string why);
		$display("Simulation FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_val(input string name, input data_t exp, input data_t got);
		if (got !== exp) begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
			abort_run("value mismatch");
		end
	endtask

	// next edge, then step off it to drive and sample
	task automatic wait_cycle();
		@(posedge clk100);
		#1;
		if (io_house_top_inst.io_house_checker_inst.assert_failed)
			abort_run("assertion in io_house_checker failed");
	endtask

	// ------------------------------------------------------------------
	// bus master
	// ------------------------------------------------------------------
	task automatic bus_access(input addr_t adr, input logic we, input sel_t sel,
			input data_t wdat, output data_t rdat);
		int n;
		n = 0;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
		do begin
			wait_cycle();
			n++;
			if (n > ACK_LIMIT)
				abort_run($sformatf("no ack from address %h", adr));
		end while (!resp.ack);
		rdat = resp.dat;
		req  = '0;   // cyc and stb down
		n    = 0;
		while (resp.ack) begin   // timeout ack may hang on a cycle longer
			wait_cycle();
			n++;
			if (n > 4)
				abort_run("ack stuck high after the request ended");
		end
		wait_cycle();   // idle gap
	endtask

	initial begin
		data_t   val;
		data_t   rd;
		clk_en_t en_exp;
		logic    tick_prev;
		int      falls;
		int      n;
		rst = 1'b1;
		req = '0;
		repeat (16) @(posedge clk100);
		#1;
		rst = 1'b0;
		wait_cycle();
		check_val("clk_en_o", 32'h6, {29'h0, clk_en});

		// ------------------------------------------------------------------
		// led register
		// ------------------------------------------------------------------
		repeat (4) begin
			draw_bits(8, val);
			bus_access(LEDS_ADR, 1'b1, 4'b0001, val, rd);
			bus_access(LEDS_ADR, 1'b0, 4'b1111, '0, rd);
			check_val("resp_o.dat", {24'h0, val[7:0]}, rd);   // upper bytes zero
		end
		check_val("led_o", {24'h0, val[7:0]}, {24'h0, led});

		// clock enables from the upper lanes, core 2 left off
		draw_bits(3, val);
		val[2] = 1'b0;
		en_exp = val[2:0];
		bus_access(RST_ADR, 1'b1, 4'b1100, {13'h0, en_exp, 16'h0}, rd);
		check_val("clk_en_o", {29'h0, en_exp}, {29'h0, clk_en});

		// reset pulse, bit 4 also wakes core 2
		draw_bits(16, val);
		val[4] = 1'b1;
		bus_access(RST_ADR, 1'b1, 4'b0011, {16'h0, val[15:0]}, rd);
		en_exp[2] = 1'b1;
		check_val("clk_en_o", {29'h0, en_exp}, {29'h0, clk_en});
		n = 0;
		while (core_rst != '0) begin
			wait_cycle();
			n++;
			if (n > PULSE_LIMIT)
				abort_run("core reset pulse never ended");
		end
		bus_access(RST_ADR, 1'b0, 4'b1111, '0, rd);
		check_val("resp_o.dat", 32'h0, rd);

		// empty slot in the io page
		bus_access(EMPTY_ADR, 1'b0, 4'b1111, '0, rd);
		check_val("resp_o.dat", 32'hFFFF_FFFF, rd);

		// ------------------------------------------------------------------
		// tick interrupt, two full windows
		// ------------------------------------------------------------------
		falls = 0;
		n     = 0;
		while (falls < 2) begin
			tick_prev = tick_irq;
			wait_cycle();
			if (tick_prev && !tick_irq)
				falls++;
			n++;
			if (n > TICK_LIMIT)
				abort_run("tick interrupt did not toggle");
		end

		wait_cycle();
		if (io_house_top_inst.io_house_checker_inst.assert_failed)
			abort_run("assertion in io_house_checker failed");
		else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule
